//--- bench/rv_alu_checker.sv
`default_nettype none

`include "rv_alu_params.svh"

module rv_alu_checker
    import rv_alu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      instr_valid,
    input  wire logic      instr_ready,
    input  wire instr_t    instr,
    input  wire logic      res_req,
    input  wire logic      res_ack,
    input  wire reg_addr_t res_rd,
    input  wire word_t     res_data,
    output int             error_count,
    output int             accepted_count,
    output int             result_count,
    output int             pending_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    word_t       model_regs [32];
    word_t       model_pc;
    // Expected results in program order with rd above data
    logic [36:0] expect_q [$];
    int          errors;
    int          accepted;
    int          results;
    logic        req_q;
    logic        ack_q;
    reg_addr_t   held_rd;
    word_t       held_data;

    // RV32I integer function selected by funct3
    function automatic word_t arith(input logic [2:0] funct3, input logic alt_sub,
                                    input logic alt_shift, input word_t x, input word_t y);
        case (funct3)
            3'b000:  return alt_sub ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101:  return alt_shift ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    // Returns one when the instruction writes a register
    function automatic logic model_step(input instr_t ins, input word_t pc_val,
                                        output word_t result);
        word_t a;
        word_t b;
        word_t imm_i;
        a      = model_regs[ins[19:15]];
        b      = model_regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        result = '0;
        case (ins[6:0])
            OPC_OP:    result = arith(ins[14:12], ins[30], ins[30], a, b);
            OPC_OPIMM: result = arith(ins[14:12], 1'b0, ins[30], a, imm_i);
            OPC_LUI:   result = {ins[31:12], 12'b0};
            OPC_AUIPC: result = pc_val + {ins[31:12], 12'b0};
            default:   return 1'b0;
        endcase
        return 1'b1;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        word_t       result;
        logic        writes;
        logic [36:0] expected;
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            model_pc = `RV_RESET_PC;
            expect_q.delete();
            errors   = 0;
            accepted = 0;
            results  = 0;
            req_q    = 1'b0;
            ack_q    = 1'b0;
        end else begin
            // Rising request carries the next result in program order
            if (res_req && !req_q) begin
                if (res_ack) begin
                    $display("res_req rose while res_ack was still high at %0t", $time);
                    errors++;
                end
                if (expect_q.size() == 0) begin
                    $display("Result for x%0d arrived with no instruction expecting one", res_rd);
                    errors++;
                end else begin
                    expected = expect_q.pop_front();
                    if (res_rd !== expected[36:32]) begin
                        $display("Mismatch res_rd: expected %h, got %h at %0t",
                                 expected[36:32], res_rd, $time);
                        errors++;
                    end
                    if (res_data !== expected[31:0]) begin
                        $display("Mismatch res_data: expected %h, got %h at %0t",
                                 expected[31:0], res_data, $time);
                        errors++;
                    end
                end
                results++;
                held_rd   = res_rd;
                held_data = res_data;
            end else if (res_req && (res_rd !== held_rd || res_data !== held_data)) begin
                $display("Result changed while res_req was high at %0t", $time);
                errors++;
            end
            if (!res_req && req_q && !ack_q) begin
                $display("res_req dropped before res_ack was raised at %0t", $time);
                errors++;
            end

            // Pipeline must hold while the result port is busy
            if (instr_ready && (res_req || res_ack)) begin
                $display("instr_ready was high while the result port was busy at %0t", $time);
                errors++;
            end

            if (instr_valid && instr_ready) begin
                writes = model_step(instr, model_pc, result);
                if (writes) begin
                    expect_q.push_back({instr[11:7], result});
                    if (instr[11:7] != 5'd0) begin
                        model_regs[instr[11:7]] = result;
                    end
                end
                model_pc = model_pc + 32'd4;
                accepted++;
            end
            req_q = res_req;
            ack_q = res_ack;
        end
        error_count    <= errors;
        accepted_count <= accepted;
        result_count   <= results;
        pending_count  <= expect_q.size();
    end

endmodule

`default_nettype wire

//--- bench/tb_rv_alu_core.sv
`default_nettype none

module tb_rv_alu_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR      = 400;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 16 + 200;

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    logic        clk         = 1'b0;
    logic        rst_n       = 1'b0;
    logic        instr_valid = 1'b0;
    logic [31:0] instr       = '0;
    logic        res_ack     = 1'b0;
    logic        instr_ready;
    logic        res_req;
    logic [4:0]  res_rd;
    logic [31:0] res_data;

    logic [31:0] stim_state = 32'd72;
    logic [31:0] ack_state  = 32'd72;
    int          cycle_count = 0;
    int          offered     = 0;
    int          ack_wait    = 0;
    int          error_count;
    int          accepted_count;
    int          result_count;
    int          pending_count;

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Upper bits only since the low bits of an LCG repeat quickly
    function automatic int next_stim();
        stim_state = lcg_step(stim_state);
        return int'(stim_state[30:16]);
    endfunction

    function automatic int next_ack_delay();
        ack_state = lcg_step(ack_state);
        return int'(ack_state[30:16]) % 5;
    endfunction

    // Registers x0 to x7 only so that dependencies are frequent
    function automatic logic [31:0] make_instr(input int index);
        int          pick;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [11:0] imm12;
        logic [4:0]  shamt;
        logic        alt;
        logic [6:0]  bad_op;
        logic [19:0] upper;
        // Load x1 to x7 first since the register file has no reset
        if (index < 7) begin
            imm12 = 12'(next_stim());
            return {imm12, 5'd0, 3'b000, 5'(index + 1), OPC_OPIMM};
        end
        pick   = next_stim() % 100;
        rd     = (next_stim() % 100 < 5) ? 5'd0 : 5'(next_stim() % 7 + 1);
        rs1    = 5'(next_stim() % 8);
        rs2    = 5'(next_stim() % 8);
        funct3 = 3'(next_stim());
        alt    = 1'(next_stim());
        imm12  = 12'(next_stim());
        shamt  = 5'(next_stim());
        upper  = {5'(next_stim()), 15'(next_stim())};
        if (pick < 5) begin
            case (next_stim() % 5)
                0:       bad_op = 7'b0000011;
                1:       bad_op = 7'b0100011;
                2:       bad_op = 7'b1100011;
                3:       bad_op = 7'b1101111;
                default: bad_op = 7'b1110011;
            endcase
            return {upper, rd, bad_op};
        end else if (pick < 45) begin
            return {1'b0, alt && (funct3 == 3'b000 || funct3 == 3'b101), 5'b0,
                    rs2, rs1, funct3, rd, OPC_OP};
        end else if (pick < 80) begin
            if (funct3 == 3'b001) begin
                imm12 = {7'b0, shamt};
            end else if (funct3 == 3'b101) begin
                imm12 = {1'b0, alt, 5'b0, shamt};
            end
            return {imm12, rs1, funct3, rd, OPC_OPIMM};
        end else if (pick < 90) begin
            return {upper, rd, OPC_LUI};
        end
        return {upper, rd, OPC_AUIPC};
    endfunction

    // Cycle count and reset release
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == RESET_CYCLES - 1) begin
            rst_n <= 1'b1;
        end
    end

    // Instruction source with random gaps in valid
    always @(posedge clk) begin
        if (rst_n && (!instr_valid || instr_ready)) begin
            if (offered < NUM_INSTR && next_stim() % 4 != 0) begin
                instr_valid <= 1'b1;
                instr       <= make_instr(offered);
                offered     <= offered + 1;
            end else begin
                instr_valid <= 1'b0;
            end
        end
    end

    // Result consumer that moves ack after 0 to 4 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            res_ack  <= 1'b0;
            ack_wait <= 0;
        end else if (res_req != res_ack) begin
            if (ack_wait == 0) begin
                res_ack  <= res_req;
                ack_wait <= next_ack_delay();
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end
    end

    rv_alu_core uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .res_req     (res_req),
        .res_ack     (res_ack),
        .res_rd      (res_rd),
        .res_data    (res_data)
    );

    rv_alu_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .instr          (instr),
        .res_req        (res_req),
        .res_ack        (res_ack),
        .res_rd         (res_rd),
        .res_data       (res_data),
        .error_count    (error_count),
        .accepted_count (accepted_count),
        .result_count   (result_count),
        .pending_count  (pending_count)
    );

    initial begin
        int end_errors;
        int total;
        end_errors = 0;
        @(posedge clk);
        while ((accepted_count < NUM_INSTR || pending_count != 0 || res_req || res_ack)
               && cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles with %0d of %0d instructions accepted",
                     cycle_count, accepted_count, NUM_INSTR);
            end_errors++;
        end else begin
            repeat (2) @(posedge clk);
        end
        if (accepted_count != NUM_INSTR) begin
            $display("Accepted %0d instructions instead of %0d", accepted_count, NUM_INSTR);
            end_errors++;
        end
        if (pending_count != 0) begin
            $display("%0d expected results never arrived", pending_count);
            end_errors++;
        end
        total = error_count + end_errors;
        $display("Errors: %0d, instructions accepted: %0d, results checked: %0d",
                 total, accepted_count, result_count);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it into sim.log and looks for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log \
    && verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_alu_core \
        -f rv_alu_core.f -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    && grep -qx "test passed" sim.log \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }

//--- rv_alu_core.f
+incdir+source
source/rv_alu_pkg.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_reg_id_ex.sv
source/rv_execute.sv
source/rv_writeback.sv
source/rv_alu_core.sv
bench/rv_alu_checker.sv
bench/tb_rv_alu_core.sv

//--- source/rv_alu_core.sv
`default_nettype none

module rv_alu_core
    import rv_alu_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,

    // Instruction stream
    input  wire logic   instr_valid,
    output logic        instr_ready,
    input  wire instr_t instr,

    // Result port, four-phase
    output logic        res_req,
    input  wire logic   res_ack,
    output reg_addr_t   res_rd,
    output word_t       res_data
);

    logic       advance;

    logic       id_valid;
    logic       reg_write_id;
    alu_op_t    alu_op_id;
    alu_a_src_t alu_a_src_id;
    logic       alu_b_imm_id;
    reg_addr_t  rd_id;
    reg_addr_t  rs1_id;
    reg_addr_t  rs2_id;
    word_t      rs1_data_id;
    word_t      rs2_data_id;
    word_t      imm_id;
    word_t      pc_id;

    logic       valid_ex;
    logic       reg_write_ex;
    alu_op_t    alu_op_ex;
    alu_a_src_t alu_a_src_ex;
    logic       alu_b_imm_ex;
    reg_addr_t  rd_ex;
    reg_addr_t  rs1_ex;
    reg_addr_t  rs2_ex;
    word_t      rs1_data_ex;
    word_t      rs2_data_ex;
    word_t      imm_ex;
    word_t      pc_ex;

    logic       ex_write;
    reg_addr_t  ex_rd;
    word_t      ex_result;

    logic       wb_held;
    reg_addr_t  wb_rd;
    word_t      wb_data;

    assign instr_ready = advance;
    assign res_rd      = wb_rd;
    assign res_data    = wb_data;

    rv_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .instr_valid (instr_valid),
        .instr       (instr),
        .id_valid    (id_valid),
        .reg_write   (reg_write_id),
        .alu_op      (alu_op_id),
        .alu_a_src   (alu_a_src_id),
        .alu_b_imm   (alu_b_imm_id),
        .rd          (rd_id),
        .rs1         (rs1_id),
        .rs2         (rs2_id),
        .rs1_data    (rs1_data_id),
        .rs2_data    (rs2_data_id),
        .imm         (imm_id),
        .pc          (pc_id),
        .wb_we       (wb_held),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    rv_reg_id_ex u_reg_id_ex (
        .clk          (clk),
        .rst_n        (rst_n),
        .advance      (advance),
        .valid_id     (id_valid),
        .reg_write_id (reg_write_id),
        .alu_op_id    (alu_op_id),
        .alu_a_src_id (alu_a_src_id),
        .alu_b_imm_id (alu_b_imm_id),
        .rd_id        (rd_id),
        .rs1_id       (rs1_id),
        .rs2_id       (rs2_id),
        .rs1_data_id  (rs1_data_id),
        .rs2_data_id  (rs2_data_id),
        .imm_id       (imm_id),
        .pc_id        (pc_id),
        .valid_ex     (valid_ex),
        .reg_write_ex (reg_write_ex),
        .alu_op_ex    (alu_op_ex),
        .alu_a_src_ex (alu_a_src_ex),
        .alu_b_imm_ex (alu_b_imm_ex),
        .rd_ex        (rd_ex),
        .rs1_ex       (rs1_ex),
        .rs2_ex       (rs2_ex),
        .rs1_data_ex  (rs1_data_ex),
        .rs2_data_ex  (rs2_data_ex),
        .imm_ex       (imm_ex),
        .pc_ex        (pc_ex)
    );

    rv_execute u_execute (
        .valid_ex     (valid_ex),
        .reg_write_ex (reg_write_ex),
        .alu_op       (alu_op_ex),
        .alu_a_src    (alu_a_src_ex),
        .alu_b_imm    (alu_b_imm_ex),
        .rd           (rd_ex),
        .rs1          (rs1_ex),
        .rs2          (rs2_ex),
        .rs1_data     (rs1_data_ex),
        .rs2_data     (rs2_data_ex),
        .imm          (imm_ex),
        .pc           (pc_ex),
        .wb_held      (wb_held),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .ex_write     (ex_write),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result)
    );

    rv_writeback u_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_write  (ex_write),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .advance   (advance),
        .wb_held   (wb_held),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .res_req   (res_req),
        .res_ack   (res_ack)
    );

endmodule

`default_nettype wire

//--- source/rv_alu_params.svh
`ifndef RV_ALU_PARAMS_SVH
`define RV_ALU_PARAMS_SVH

// Integer register and datapath width, fixed at 32 by RV32I
`define RV_XLEN 32

// Address given to the first accepted instruction
`define RV_RESET_PC 32'h0000_0000

`endif

//--- source/rv_alu_pkg.sv
`default_nettype none

`include "rv_alu_params.svh"

package rv_alu_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [31:0]         instr_t;

    // ALU functions, one per RV32I integer operation
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Operand A source, zero serves LUI
    typedef enum logic [1:0] {
        A_RS1,
        A_PC,
        A_ZERO
    } alu_a_src_t;

    // Result port handshake
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_DROP
    } wb_state_t;

endpackage

`default_nettype wire

//--- source/rv_decode.sv
`default_nettype none

`include "rv_alu_params.svh"

module rv_decode
    import rv_alu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      advance,

    input  wire logic      instr_valid,
    input  wire instr_t    instr,

    output logic           id_valid,
    output logic           reg_write,
    output alu_op_t        alu_op,
    output alu_a_src_t     alu_a_src,
    output logic           alu_b_imm,
    output reg_addr_t      rd,
    output reg_addr_t      rs1,
    output reg_addr_t      rs2,
    output word_t          rs1_data,
    output word_t          rs2_data,
    output word_t          imm,
    output word_t          pc,

    input  wire logic      wb_we,
    input  wire reg_addr_t wb_rd,
    input  wire word_t     wb_data
);

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    instr_t instr_q;
    word_t  pc_cnt;

    // Maps funct3 and bit 30 onto an ALU function
    function automatic alu_op_t decode_alu(input logic [2:0] funct3, input logic alt,
                                           input logic is_reg);
        case (funct3)
            3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            pc_cnt   <= `RV_RESET_PC;
        end else if (advance) begin
            id_valid <= instr_valid;
            if (instr_valid) begin
                pc_cnt <= pc_cnt + 32'd4;
            end
        end
    end

    // Held instruction and the address it was accepted at
    always_ff @(posedge clk) begin
        if (advance) begin
            instr_q <= instr;
            pc      <= pc_cnt;
        end
    end

    assign rd  = instr_q[11:7];
    assign rs1 = instr_q[19:15];
    assign rs2 = instr_q[24:20];

    always_comb begin
        reg_write = 1'b0;
        alu_op    = ALU_ADD;
        alu_a_src = A_RS1;
        alu_b_imm = 1'b0;
        imm       = {{20{instr_q[31]}}, instr_q[31:20]};
        case (instr_q[6:0])
            OPC_OP: begin
                reg_write = 1'b1;
                alu_op    = decode_alu(instr_q[14:12], instr_q[30], 1'b1);
            end
            OPC_OPIMM: begin
                reg_write = 1'b1;
                alu_op    = decode_alu(instr_q[14:12], instr_q[30], 1'b0);
                alu_b_imm = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                reg_write = 1'b1;
                alu_a_src = (instr_q[6:0] == OPC_LUI) ? A_ZERO : A_PC;
                alu_b_imm = 1'b1;
                imm       = {instr_q[31:12], 12'b0};
            end
            default: begin
                // Unsupported opcode passes through as a no-op
                reg_write = 1'b0;
            end
        endcase
    end

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_we),
        .rd       (wb_rd),
        .rd_data  (wb_data)
    );

endmodule

`default_nettype wire

//--- source/rv_execute.sv
`default_nettype none

module rv_execute
    import rv_alu_pkg::*;
(
    input  wire logic       valid_ex,
    input  wire logic       reg_write_ex,
    input  wire alu_op_t    alu_op,
    input  wire alu_a_src_t alu_a_src,
    input  wire logic       alu_b_imm,
    input  wire reg_addr_t  rd,
    input  wire reg_addr_t  rs1,
    input  wire reg_addr_t  rs2,
    input  wire word_t      rs1_data,
    input  wire word_t      rs2_data,
    input  wire word_t      imm,
    input  wire word_t      pc,

    // Entry held in writeback
    input  wire logic       wb_held,
    input  wire reg_addr_t  wb_rd,
    input  wire word_t      wb_data,

    output logic            ex_write,
    output reg_addr_t       ex_rd,
    output word_t           ex_result
);

    word_t      rs1_val;
    word_t      rs2_val;
    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    // The register file missed the producer one stage ahead, take it from writeback
    assign rs1_val = (wb_held && (wb_rd != '0) && (wb_rd == rs1)) ? wb_data : rs1_data;
    assign rs2_val = (wb_held && (wb_rd != '0) && (wb_rd == rs2)) ? wb_data : rs2_data;

    always_comb begin
        case (alu_a_src)
            A_RS1:   op_a = rs1_val;
            A_PC:    op_a = pc;
            default: op_a = '0;
        endcase
    end

    assign op_b  = alu_b_imm ? imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        ex_result = '0;
        case (alu_op)
            ALU_ADD:  ex_result = op_a + op_b;
            ALU_SUB:  ex_result = op_a - op_b;
            ALU_SLL:  ex_result = op_a << shamt;
            ALU_SLT:  ex_result[0] = $signed(op_a) < $signed(op_b);
            ALU_SLTU: ex_result[0] = op_a < op_b;
            ALU_XOR:  ex_result = op_a ^ op_b;
            ALU_SRL:  ex_result = op_a >> shamt;
            ALU_SRA:  ex_result = $signed(op_a) >>> shamt;
            ALU_OR:   ex_result = op_a | op_b;
            default:  ex_result = op_a & op_b;
        endcase
    end

    assign ex_write = valid_ex && reg_write_ex;
    assign ex_rd    = rd;

endmodule

`default_nettype wire

//--- source/rv_reg_id_ex.sv
`default_nettype none

module rv_reg_id_ex
    import rv_alu_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       advance,

    // Decode side
    input  wire logic       valid_id,
    input  wire logic       reg_write_id,
    input  wire alu_op_t    alu_op_id,
    input  wire alu_a_src_t alu_a_src_id,
    input  wire logic       alu_b_imm_id,
    input  wire reg_addr_t  rd_id,
    input  wire reg_addr_t  rs1_id,
    input  wire reg_addr_t  rs2_id,
    input  wire word_t      rs1_data_id,
    input  wire word_t      rs2_data_id,
    input  wire word_t      imm_id,
    input  wire word_t      pc_id,

    // Execute side
    output logic            valid_ex,
    output logic            reg_write_ex,
    output alu_op_t         alu_op_ex,
    output alu_a_src_t      alu_a_src_ex,
    output logic            alu_b_imm_ex,
    output reg_addr_t       rd_ex,
    output reg_addr_t       rs1_ex,
    output reg_addr_t       rs2_ex,
    output word_t           rs1_data_ex,
    output word_t           rs2_data_ex,
    output word_t           imm_ex,
    output word_t           pc_ex
);

    // Stage occupancy and write enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_ex     <= 1'b0;
            reg_write_ex <= 1'b0;
        end else if (advance) begin
            valid_ex     <= valid_id;
            reg_write_ex <= reg_write_id;
        end
    end

    // Control selects and register numbers
    always_ff @(posedge clk) begin
        if (advance) begin
            alu_op_ex    <= alu_op_id;
            alu_a_src_ex <= alu_a_src_id;
            alu_b_imm_ex <= alu_b_imm_id;
            rd_ex        <= rd_id;
            rs1_ex       <= rs1_id;
            rs2_ex       <= rs2_id;
        end
    end

    // Operands
    always_ff @(posedge clk) begin
        if (advance) begin
            rs1_data_ex <= rs1_data_id;
            rs2_data_ex <= rs2_data_id;
            imm_ex      <= imm_id;
            pc_ex       <= pc_id;
        end
    end

endmodule

`default_nettype wire

//--- source/rv_regfile.sv
`default_nettype none

module rv_regfile
    import rv_alu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,

    input  wire reg_addr_t rs1,
    input  wire reg_addr_t rs2,
    output word_t          rs1_data,
    output word_t          rs2_data,

    input  wire logic      we,
    input  wire reg_addr_t rd,
    input  wire word_t     rd_data
);

    word_t regs [32];

    // Writes are ignored while reset is held, and x0 is never written
    always_ff @(posedge clk) begin
        if (rst_n && we && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

    // Combinational reads, x0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- source/rv_writeback.sv
`default_nettype none

module rv_writeback
    import rv_alu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,

    input  wire logic      ex_write,
    input  wire reg_addr_t ex_rd,
    input  wire word_t     ex_result,

    output logic           advance,
    output logic           wb_held,
    output reg_addr_t      wb_rd,
    output word_t          wb_data,

    output logic           res_req,
    input  wire logic      res_ack
);

    wb_state_t state;

    // Pipeline moves only while the result port is idle
    assign advance = (state == WB_IDLE);
    assign res_req = (state == WB_REQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= WB_IDLE;
            wb_held <= 1'b0;
        end else begin
            case (state)
                WB_IDLE: begin
                    // A bubble or non-writing instruction empties the entry
                    wb_held <= ex_write;
                    if (ex_write) begin
                        state <= WB_REQ;
                    end
                end
                WB_REQ: begin
                    if (res_ack) begin
                        state <= WB_DROP;
                    end
                end
                WB_DROP: begin
                    // Wait for the consumer to release ack
                    if (!res_ack) begin
                        state <= WB_IDLE;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // Result entry, stable for the whole handshake
    always_ff @(posedge clk) begin
        if (advance && ex_write) begin
            wb_rd   <= ex_rd;
            wb_data <= ex_result;
        end
    end

endmodule

`default_nettype wire
